// ==== common/cpu_config.svh ====
// processor configuration macros
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath widths
`define CPU_WORD_WIDTH      16
`define CPU_PC_WIDTH        12
`define CPU_REG_COUNT       16
`define CPU_REG_ADDR_WIDTH  4
`define CPU_DATA_ADDR_WIDTH 12
`define CPU_INSTR_WIDTH     16

// instruction field positions
`define CPU_BIT_CTRL  15
`define CPU_BIT_MEM   14
`define CPU_BIT_VAR   13
`define CPU_RS_MSB    12
`define CPU_RS_LSB    9
`define CPU_RT_MSB    8
`define CPU_RT_LSB    5
`define CPU_RD_MSB    4
`define CPU_RD_LSB    1
`define CPU_BIT_FN_LO 0
`define CPU_IMM_MSB   4
`define CPU_IMM_LSB   0
`define CPU_JMP_MSB   12
`define CPU_JMP_LSB   1

`endif

// ==== common/cpu_pkg.sv ====
// processor shared types
`include "cpu_config.svh"

package cpu_pkg;

    // register value, signed for slt and multiply
    typedef logic signed [`CPU_WORD_WIDTH-1:0] word_t;

    // instruction word address
    typedef logic [`CPU_PC_WIDTH-1:0] pc_t;

    typedef logic [`CPU_INSTR_WIDTH-1:0] instr_t;

    typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // data memory word address
    typedef logic [`CPU_DATA_ADDR_WIDTH-1:0] data_addr_t;

    // control sequencer states
    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_execute,
        st_mem,
        st_mem_wait,
        st_halt
    } ctrl_state_t;

endpackage

// ==== source/cpu_control.sv ====
// processor control sequencer
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_control (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            fetch_valid,
    input  logic            mem_rvalid,
    input  logic            mem_wack,
    input  cpu_pkg::instr_t fetch_instr,
    input  cpu_pkg::pc_t    pc,
    output cpu_pkg::instr_t instr,
    output logic            fetch_req,
    output logic            mem_rd_req,
    output logic            mem_wr_req,
    output logic            reg_we,
    output logic            pc_advance,
    output logic            retire,
    output logic            halted
);

    cpu_pkg::ctrl_state_t state;
    cpu_pkg::ctrl_state_t state_next;

    logic is_ctrl;
    logic is_mem;
    logic is_load;
    logic is_alu;
    logic pc_over;
    logic mem_done;

    // ####################
    // decode
    assign is_ctrl = instr[`CPU_BIT_CTRL];
    assign is_mem  = !is_ctrl && instr[`CPU_BIT_MEM];
    assign is_load = is_mem && instr[`CPU_BIT_VAR];
    assign is_alu  = !is_ctrl && !is_mem;

    // program ran past the last instruction word
    assign pc_over = pc[`CPU_PC_WIDTH-1];

    assign mem_done = is_load ? mem_rvalid : mem_wack;

    // ####################
    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::st_fetch;
        end else begin
            state <= state_next;
        end
    end

    // instruction register, loaded when the fetch answer arrives
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::st_fetch_wait && fetch_valid) begin
            instr <= fetch_instr;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::st_fetch: begin
                state_next = pc_over ? cpu_pkg::st_halt : cpu_pkg::st_fetch_wait;
            end
            cpu_pkg::st_fetch_wait: begin
                if (fetch_valid) begin
                    state_next = cpu_pkg::st_execute;
                end
            end
            cpu_pkg::st_execute: begin
                state_next = is_mem ? cpu_pkg::st_mem : cpu_pkg::st_fetch;
            end
            cpu_pkg::st_mem: begin
                state_next = cpu_pkg::st_mem_wait;
            end
            cpu_pkg::st_mem_wait: begin
                if (mem_done) begin
                    state_next = cpu_pkg::st_fetch;
                end
            end
            default: begin
                state_next = cpu_pkg::st_halt;
            end
        endcase
    end

    // ####################
    // strobes
    assign fetch_req  = (state == cpu_pkg::st_fetch) && !pc_over;
    assign mem_rd_req = (state == cpu_pkg::st_mem) && is_load;
    assign mem_wr_req = (state == cpu_pkg::st_mem) && !is_load;

    // alu and branch retire in execute, memory ops on their response
    assign retire = ((state == cpu_pkg::st_execute) && !is_mem)
                 || ((state == cpu_pkg::st_mem_wait) && mem_done);
    assign pc_advance = retire;

    assign reg_we = ((state == cpu_pkg::st_execute) && is_alu)
                 || ((state == cpu_pkg::st_mem_wait) && is_load && mem_rvalid);

    assign halted = (state == cpu_pkg::st_halt);

endmodule

// ==== source/program_counter.sv ====
// program counter
`timescale 1ns/10ps
`include "cpu_config.svh"

module program_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_advance,
    input  cpu_pkg::instr_t instr,
    input  cpu_pkg::word_t  rs_val,
    input  cpu_pkg::word_t  rt_val,
    output cpu_pkg::pc_t    pc
);

    localparam int IMM_WIDTH = `CPU_IMM_MSB - `CPU_IMM_LSB + 1;

    cpu_pkg::pc_t pc_inc;
    cpu_pkg::pc_t branch_off;
    cpu_pkg::pc_t pc_next;

    assign pc_inc = pc + cpu_pkg::pc_t'(1);

    // immediate widened to pc width
    assign branch_off = {{(`CPU_PC_WIDTH - IMM_WIDTH){instr[`CPU_IMM_MSB]}},
                         instr[`CPU_IMM_MSB:`CPU_IMM_LSB]};

    always_comb begin
        pc_next = pc_inc;
        if (instr[`CPU_BIT_CTRL]) begin
            if (!instr[`CPU_BIT_VAR]) begin
                pc_next = instr[`CPU_JMP_MSB:`CPU_JMP_LSB];
            end else if (rs_val == rt_val) begin
                // taken beq, wraps mod 4096
                pc_next = pc_inc + branch_off;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_advance) begin
            pc <= pc_next;
        end
    end

endmodule

// ==== execute/register_file.sv ====
// sixteen entry register file
`timescale 1ns/10ps
`include "cpu_config.svh"

module register_file (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::instr_t instr,
    input  logic            reg_we,
    input  cpu_pkg::word_t  alu_result,
    input  cpu_pkg::word_t  mem_rdata,
    output cpu_pkg::word_t  rs_val,
    output cpu_pkg::word_t  rt_val
);

    cpu_pkg::word_t regs [`CPU_REG_COUNT];

    cpu_pkg::reg_addr_t rs_addr;
    cpu_pkg::reg_addr_t rt_addr;
    cpu_pkg::reg_addr_t rd_addr;

    assign rs_addr = instr[`CPU_RS_MSB:`CPU_RS_LSB];
    assign rt_addr = instr[`CPU_RT_MSB:`CPU_RT_LSB];
    assign rd_addr = instr[`CPU_RD_MSB:`CPU_RD_LSB];

    // two combinational read ports
    assign rs_val = regs[rs_addr];
    assign rt_val = regs[rt_addr];

    // loads target rt, alu ops target rd
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            if (instr[`CPU_BIT_MEM]) begin
                regs[rt_addr] <= mem_rdata;
            end else begin
                regs[rd_addr] <= alu_result;
            end
        end
    end

endmodule

// ==== execute/alu.sv ====
// arithmetic unit and data address adder
`timescale 1ns/10ps
`include "cpu_config.svh"

module alu (
    input  cpu_pkg::instr_t     instr,
    input  cpu_pkg::word_t      rs_val,
    input  cpu_pkg::word_t      rt_val,
    output cpu_pkg::word_t      alu_result,
    output cpu_pkg::data_addr_t mem_addr
);

    localparam int IMM_WIDTH = `CPU_IMM_MSB - `CPU_IMM_LSB + 1;

    logic [1:0]          func;
    cpu_pkg::data_addr_t addr_off;

    assign func = {instr[`CPU_BIT_VAR], instr[`CPU_BIT_FN_LO]};

    always_comb begin
        case (func)
            2'b00: alu_result = rs_val - rt_val;
            2'b01: alu_result = rs_val + rt_val;
            // low half of the product only
            2'b10: alu_result = rs_val * rt_val;
            default: alu_result = (rs_val < rt_val) ? cpu_pkg::word_t'(1) : '0;
        endcase
    end

    // ####################
    // data address
    assign addr_off = {{(`CPU_DATA_ADDR_WIDTH - IMM_WIDTH){instr[`CPU_IMM_MSB]}},
                       instr[`CPU_IMM_MSB:`CPU_IMM_LSB]};

    assign mem_addr = rs_val[`CPU_DATA_ADDR_WIDTH-1:0] + addr_off;

endmodule

// ==== source/cpu_top.sv ====
// processor top level
`timescale 1ns/10ps

module cpu_top (
    input  logic                clk,
    input  logic                rst_n,

    // instruction fetch port
    output logic                fetch_req,
    output cpu_pkg::pc_t        fetch_addr,
    input  logic                fetch_valid,
    input  cpu_pkg::instr_t     fetch_instr,

    // data port
    output logic                mem_rd_req,
    output logic                mem_wr_req,
    output cpu_pkg::data_addr_t mem_addr,
    output cpu_pkg::word_t      mem_wdata,
    input  logic                mem_rvalid,
    input  cpu_pkg::word_t      mem_rdata,
    input  logic                mem_wack,

    output logic                retire,
    output logic                halted
);

    cpu_pkg::instr_t instr;
    cpu_pkg::pc_t    pc;
    cpu_pkg::word_t  rs_val;
    cpu_pkg::word_t  rt_val;
    cpu_pkg::word_t  alu_result;
    logic            reg_we;
    logic            pc_advance;

    assign fetch_addr = pc;
    assign mem_wdata  = rt_val;

    cpu_control u_cpu_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .mem_rvalid  (mem_rvalid),
        .mem_wack    (mem_wack),
        .fetch_instr (fetch_instr),
        .pc          (pc),
        .instr       (instr),
        .fetch_req   (fetch_req),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .reg_we      (reg_we),
        .pc_advance  (pc_advance),
        .retire      (retire),
        .halted      (halted)
    );

    program_counter u_program_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_advance (pc_advance),
        .instr      (instr),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .pc         (pc)
    );

    register_file u_register_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .reg_we     (reg_we),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .rs_val     (rs_val),
        .rt_val     (rt_val)
    );

    alu u_alu (
        .instr      (instr),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .alu_result (alu_result),
        .mem_addr   (mem_addr)
    );

endmodule

// ==== test/tb_cpu_top.sv ====
// processor testbench
`timescale 1ns/10ps

module tb_cpu_top;

    localparam int BODY_LEN    = 64;
    localparam int RUN_TIMEOUT = 20000;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    logic                fetch_valid = 1'b0;
    cpu_pkg::instr_t     fetch_instr = '0;
    logic                mem_rvalid = 1'b0;
    logic                mem_wack = 1'b0;
    cpu_pkg::word_t      mem_rdata = '0;
    logic                fetch_req;
    logic                mem_rd_req;
    logic                mem_wr_req;
    logic                retire;
    logic                halted;
    cpu_pkg::pc_t        fetch_addr;
    cpu_pkg::data_addr_t mem_addr;
    cpu_pkg::word_t      mem_wdata;

    cpu_pkg::instr_t imem [4096];
    cpu_pkg::word_t  dmem_init [4096];
    cpu_pkg::word_t  dmem [4096];

    // expected behavior from the reference model
    cpu_pkg::pc_t        exp_fetch [$];
    cpu_pkg::data_addr_t exp_store_addr [$];
    cpu_pkg::word_t      exp_store_data [$];
    int                  exp_retires;

    int fetch_idx = 0;
    int store_idx = 0;
    int retire_count = 0;

    // pending memory responses
    int                  fetch_cnt = 0;
    int                  data_cnt = 0;
    cpu_pkg::pc_t        fetch_pend;
    cpu_pkg::data_addr_t data_pend;
    logic                data_read;

    cpu_top UUT (.*);

    always #5 clk = ~clk;

    function automatic void report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endfunction

    function automatic void abort_on_timeout(input string msg);
        $display("Timeout: %s", msg);
        $display("Done: errors found");
        $fatal(1);
    endfunction

    // ####################
    // program and reference model
    function automatic void build_program();
        int                 kind;
        int                 room;
        cpu_pkg::reg_addr_t rs;
        cpu_pkg::reg_addr_t rt;
        cpu_pkg::reg_addr_t rd;
        logic [4:0]         imm;
        for (int i = 0; i < 4096; i++) begin
            imem[i] = cpu_pkg::instr_t'(i);
        end
        for (int addr = 0; addr < BODY_LEN; addr++) begin
            // a few loads first so the registers hold data
            kind = (addr < 6) ? 4 : int'($urandom_range(9));
            rs   = cpu_pkg::reg_addr_t'($urandom_range(15));
            rt   = cpu_pkg::reg_addr_t'($urandom_range(15));
            rd   = cpu_pkg::reg_addr_t'($urandom_range(15, 1));
            imm  = 5'($urandom);
            room = (BODY_LEN - addr - 1 > 15) ? 15 : BODY_LEN - addr - 1;
            case (kind)
                4: imem[addr] = {3'b011, 4'd0, rd, imm};
                5: imem[addr] = {3'b011, rd, rd, imm};
                6: imem[addr] = {3'b010, 4'd0, rt, imm};
                7, 8: imem[addr] = {3'b101, rs, ($urandom_range(1) == 1) ? rs : rt,
                                    5'($urandom_range(room))};
                9: imem[addr] = {3'b100,
                                 cpu_pkg::pc_t'($urandom_range(BODY_LEN, addr + 1)), 1'b0};
                default: imem[addr] = {2'b00, 1'($urandom), rs, rt, rd, 1'($urandom)};
            endcase
        end
        // dump every register and leave the program space
        for (int r = 0; r < 16; r++) begin
            imem[BODY_LEN + r] = {3'b010, 4'd0, 4'(r), 5'(r)};
        end
        imem[BODY_LEN + 16] = {3'b100, 12'h800, 1'b0};
    endfunction

    function automatic void run_reference();
        cpu_pkg::word_t      regs [16];
        cpu_pkg::word_t      mem [4096];
        cpu_pkg::instr_t     ins;
        cpu_pkg::pc_t        pc;
        cpu_pkg::data_addr_t addr;
        int                  a;
        int                  b;
        int                  imm;
        int                  steps;
        mem = dmem_init;
        pc = '0;
        steps = 0;
        exp_retires = 0;
        for (int r = 0; r < 16; r++) begin
            regs[r] = '0;
        end
        while (!pc[11]) begin
            steps++;
            if (steps > RUN_TIMEOUT) begin
                abort_on_timeout("reference model never reached the halt address");
            end
            exp_fetch.push_back(pc);
            exp_retires++;
            ins  = imem[pc];
            a    = int'(regs[ins[12:9]]);
            b    = int'(regs[ins[8:5]]);
            imm  = ins[4] ? int'(ins[4:0]) - 32 : int'(ins[4:0]);
            addr = cpu_pkg::data_addr_t'(a + imm);
            pc   = pc + 12'd1;
            if (ins[15] && ins[13]) begin
                // branch offset counts from the next word
                if (a == b) begin
                    pc = cpu_pkg::pc_t'(int'(pc) + imm);
                end
            end else if (ins[15]) begin
                pc = ins[12:1];
            end else if (ins[14] && ins[13]) begin
                regs[ins[8:5]] = mem[addr];
            end else if (ins[14]) begin
                mem[addr] = regs[ins[8:5]];
                exp_store_addr.push_back(addr);
                exp_store_data.push_back(regs[ins[8:5]]);
            end else begin
                case ({ins[13], ins[0]})
                    2'b00: regs[ins[4:1]] = cpu_pkg::word_t'(a - b);
                    2'b01: regs[ins[4:1]] = cpu_pkg::word_t'(a + b);
                    2'b10: regs[ins[4:1]] = cpu_pkg::word_t'(a * b);
                    default: regs[ins[4:1]] = (a < b) ? 16'sd1 : 16'sd0;
                endcase
            end
        end
    endfunction

    // ####################
    // memory models answer after 1 to 4 cycles
    always @(posedge clk) begin
        fetch_valid <= 1'b0;
        mem_rvalid  <= 1'b0;
        mem_wack    <= 1'b0;
        if (!rst_n) begin
            fetch_cnt = 0;
            data_cnt  = 0;
            dmem      = dmem_init;
        end else begin
            if (fetch_req) begin
                fetch_pend = fetch_addr;
                fetch_cnt  = int'($urandom_range(4, 1));
            end
            if (mem_rd_req || mem_wr_req) begin
                data_pend = mem_addr;
                data_read = mem_rd_req;
                data_cnt  = int'($urandom_range(4, 1));
                if (mem_wr_req) begin
                    dmem[mem_addr] = mem_wdata;
                end
            end
            if (fetch_cnt == 1) begin
                fetch_valid <= 1'b1;
                fetch_instr <= imem[fetch_pend];
            end
            if (data_cnt == 1) begin
                mem_rvalid <= data_read;
                mem_wack   <= !data_read;
                mem_rdata  <= dmem[data_pend];
            end
            fetch_cnt = (fetch_cnt > 0) ? fetch_cnt - 1 : 0;
            data_cnt  = (data_cnt > 0) ? data_cnt - 1 : 0;
        end
    end

    // compare fetches, stores and retires with the model
    always @(posedge clk) begin
        if (rst_n) begin
            if (fetch_req) begin
                assert (fetch_idx < exp_fetch.size())
                else report_mismatch("fetch beyond the expected sequence");
                assert (fetch_addr == exp_fetch[fetch_idx])
                else report_mismatch($sformatf("fetch %0d at %0d, expected %0d",
                                               fetch_idx, fetch_addr, exp_fetch[fetch_idx]));
                // one retire for every instruction before this fetch
                assert (retire_count == fetch_idx)
                else report_mismatch($sformatf("fetch %0d seen after %0d retires",
                                               fetch_idx, retire_count));
                fetch_idx++;
            end
            if (mem_wr_req) begin
                assert (store_idx < exp_store_addr.size())
                else report_mismatch("store beyond the expected list");
                assert (mem_addr == exp_store_addr[store_idx]
                        && mem_wdata == exp_store_data[store_idx])
                else report_mismatch($sformatf("store %0d to %0d data %0d, expected %0d data %0d",
                                               store_idx, mem_addr, mem_wdata,
                                               exp_store_addr[store_idx],
                                               exp_store_data[store_idx]));
                store_idx++;
            end
            if (retire) begin
                retire_count++;
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'hd0be));
        for (int i = 0; i < 4096; i++) begin
            dmem_init[i] = cpu_pkg::word_t'($urandom);
        end
        build_program();
        run_reference();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (fetch_req && fetch_addr == '0 && !mem_rd_req && !mem_wr_req
                && !retire && !halted)
        else report_mismatch("first cycle after reset is not a fetch of address zero");
        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                abort_on_timeout("processor did not halt within the cycle limit");
            end
        end
        // halted must hold with the bus quiet
        repeat (50) begin
            @(posedge clk);
            assert (halted && !fetch_req && !mem_rd_req && !mem_wr_req && !retire)
            else report_mismatch("strobe or halt drop seen after halt");
        end
        assert (fetch_idx == exp_fetch.size() && store_idx == exp_store_addr.size()
                && retire_count == exp_retires) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_mismatch($sformatf("fetches %0d/%0d stores %0d/%0d retires %0d/%0d",
                                      fetch_idx, exp_fetch.size(), store_idx,
                                      exp_store_addr.size(), retire_count, exp_retires));
        end
    end

endmodule

// ==== cpu_top.f ====
+incdir+common
common/cpu_pkg.sv
source/cpu_control.sv
source/program_counter.sv
execute/register_file.sv
execute/alu.sv
source/cpu_top.sv
test/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = tb_cpu_top
FILELIST  = cpu_top.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# the simulator exits non-zero on $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
